/* design/aud_pkg.sv */
package aud_pkg;

    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 20;

    // wishbone word offsets
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_END    = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;

    localparam int BCLK_DIV    = 2;  // i_clk cycles per half bit clock
    localparam int BITS_PER_CH = 16; // bit clocks per lr half
    localparam int BCLK_CNT_W  = $clog2(BCLK_DIV);
    localparam int BIT_CNT_W   = $clog2(BITS_PER_CH);

    // (v * RECIP[s]) >> 16 approximates v / s
    // entry 1 is pass through, the dsp skips the multiply at speed 1
    localparam logic [15:0] RECIP [16] = '{
        16'h0000, 16'hFFFF, 16'h8000, 16'h5555,
        16'h4000, 16'h3333, 16'h2AAA, 16'h2492,
        16'h2000, 16'h1C71, 16'h1999, 16'h1745,
        16'h1555, 16'h13B1, 16'h1249, 16'h1111
    };

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_PLAY  = 2'd1,
        ST_PAUSE = 2'd2
    } play_state_e;

endpackage

/* design/aud_wb_regs.sv */
module aud_wb_regs
    import aud_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wb_cyc,
    input  logic              i_wb_stb,
    input  logic              i_wb_we,
    input  logic [1:0]        i_wb_adr,
    input  logic [31:0]       i_wb_dat,
    input  play_state_e       i_state,
    input  logic [ADDR_W-1:0] i_addr,
    output logic [31:0]       o_wb_dat,
    output logic              o_wb_ack,
    output logic              o_start,
    output logic              o_stop,
    output logic              o_pause,
    output logic              o_fast,
    output logic              o_interp,
    output logic [3:0]        o_speed,
    output logic [ADDR_W-1:0] o_end_addr
);

    logic        wb_req;
    logic        wb_wr;
    logic        ctrl_wr;
    logic [31:0] rd_word;

    assign wb_req  = i_wb_cyc & i_wb_stb & ~o_wb_ack; // new single-beat request
    assign wb_wr   = wb_req & i_wb_we;                // commits on the edge that raises ack
    assign ctrl_wr = wb_wr & (i_wb_adr == REG_CTRL);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_req;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_start    <= 1'b0;
            o_stop     <= 1'b0;
            o_pause    <= 1'b0;
            o_fast     <= 1'b0;
            o_interp   <= 1'b0;
            o_speed    <= 4'd0;
            o_end_addr <= '0;
        end else begin
            o_start <= ctrl_wr & i_wb_dat[0]; // one-cycle pulses
            o_stop  <= ctrl_wr & i_wb_dat[2];
            if (ctrl_wr) begin
                o_pause  <= i_wb_dat[1];
                o_fast   <= i_wb_dat[3];
                o_interp <= i_wb_dat[4];
                o_speed  <= i_wb_dat[11:8];
            end
            if (wb_wr && i_wb_adr == REG_END) begin
                o_end_addr <= i_wb_dat[ADDR_W-1:0];
            end
        end
    end

    always_comb begin
        case (i_wb_adr)
            REG_CTRL: begin
                rd_word = {20'd0, o_speed, 3'd0, o_interp, o_fast, 1'b0, o_pause, 1'b0};
            end
            REG_END: begin
                rd_word = {{(32 - ADDR_W){1'b0}}, o_end_addr};
            end
            REG_STATUS: begin
                rd_word = {i_addr, 10'd0, i_state}; // live state and address
            end
            default: begin
                rd_word = 32'd0;
            end
        endcase
    end

    // read word is held while ack is high
    always_ff @(posedge i_clk) begin
        if (wb_req) begin
            o_wb_dat <= rd_word;
        end
    end

endmodule

/* design/aud_i2s_tx.sv */
module aud_i2s_tx
    import aud_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic [SAMPLE_W-1:0] i_sample,
    output logic                o_dac_bclk,
    output logic                o_dac_lrck,
    output logic                o_dac_sdata,
    output logic                o_lrck_fall
);

    logic [BCLK_CNT_W-1:0] div_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [SAMPLE_W-1:0]   shreg;
    logic                  div_wrap;
    logic                  bclk_fall;
    logic                  half_end;

    assign div_wrap  = (div_cnt == BCLK_CNT_W'(BCLK_DIV - 1));
    assign bclk_fall = o_dac_bclk & div_wrap;
    assign half_end  = (bit_cnt == BIT_CNT_W'(BITS_PER_CH - 1)); // last slot of a half

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt    <= '0;
            o_dac_bclk <= 1'b0;
        end else if (div_wrap) begin
            div_cnt    <= '0;
            o_dac_bclk <= ~o_dac_bclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // slot counter and lr clock both move on bclk falling edges
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt     <= '0;
            o_dac_lrck  <= 1'b0;
            o_lrck_fall <= 1'b0;
        end else begin
            o_lrck_fall <= bclk_fall & half_end & o_dac_lrck;
            if (bclk_fall) begin
                bit_cnt <= half_end ? '0 : bit_cnt + 1'b1;
                if (half_end) begin
                    o_dac_lrck <= ~o_dac_lrck;
                end
            end
        end
    end

    // msb lands in left slot 1 after the one bclk delay of standard i2s
    // lsb goes out in right slot 0 on the same edge that loads the next word
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            shreg       <= '0;
            o_dac_sdata <= 1'b0;
        end else if (bclk_fall) begin
            if (!o_dac_lrck) begin
                o_dac_sdata <= shreg[SAMPLE_W-1];
                shreg       <= half_end ? i_sample : {shreg[SAMPLE_W-2:0], 1'b0};
            end else begin
                o_dac_sdata <= 1'b0; // right channel is silent
            end
        end
    end

endmodule

/* design/aud_dsp.sv */
module aud_dsp
    import aud_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  logic                i_stop,
    input  logic                i_pause,
    input  logic                i_fast,
    input  logic                i_interp,
    input  logic [3:0]          i_speed,
    input  logic [ADDR_W-1:0]   i_end_addr,
    input  logic                i_lrck_fall,
    input  logic [SAMPLE_W-1:0] i_sram_data,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sample,
    output play_state_e         o_state
);

    play_state_e         state_q;
    play_state_e         state_d;
    logic [ADDR_W-1:0]   addr_q;
    logic [ADDR_W-1:0]   addr_d;
    logic [SAMPLE_W-1:0] prev_q;
    logic [SAMPLE_W-1:0] prev_d;
    logic [SAMPLE_W-1:0] sample_q;
    logic [SAMPLE_W-1:0] sample_d;
    logic [3:0]          cnt_q;
    logic [3:0]          cnt_d;
    logic [3:0]          speed;
    logic [3:0]          span;
    logic                advance;
    logic [ADDR_W:0]     addr_sum;
    logic                at_end;
    logic [SAMPLE_W-1:0] recip_prev;
    logic [SAMPLE_W-1:0] recip_next;
    logic [19:0]         interp_sum;
    logic [SAMPLE_W-1:0] step_word;

    function automatic logic [SAMPLE_W-1:0] recip_scale(input logic [SAMPLE_W-1:0] v,
                                                        input logic [3:0] s);
        logic [31:0] prod;
        prod = 32'(v) * 32'(RECIP[s]);
        if (s == 4'd1) begin
            return v;
        end
        return prod[31:16];
    endfunction

    assign speed = (i_speed == 4'd0) ? 4'd1 : i_speed; // speed 0 acts as 1
    assign span  = speed - cnt_q;

    // slow mode moves to the next word once every speed frames
    assign advance  = i_fast | (cnt_q >= speed - 4'd1);
    assign addr_sum = {1'b0, addr_q} + (i_fast ? (ADDR_W + 1)'(speed) : (ADDR_W + 1)'(1));
    assign at_end   = (addr_sum >= {1'b0, i_end_addr});

    assign recip_prev = recip_scale(prev_q, speed);
    assign recip_next = recip_scale(i_sram_data, speed);
    assign interp_sum = 20'(recip_prev) * 20'(span) + 20'(recip_next) * 20'(cnt_q);
    assign step_word  = (i_fast | ~i_interp) ? prev_q : interp_sum[SAMPLE_W-1:0];

    always_comb begin
        state_d  = state_q;
        addr_d   = addr_q;
        prev_d   = prev_q;
        sample_d = sample_q;
        cnt_d    = cnt_q;
        case (state_q)
            ST_IDLE: begin
                if (i_start) begin // addr is 0 here, so sram shows mem[0]
                    state_d = ST_PLAY;
                    prev_d  = i_sram_data;
                    addr_d  = i_fast ? ADDR_W'(speed) : ADDR_W'(1);
                    cnt_d   = 4'd0;
                end
            end
            ST_PLAY: begin
                if (i_stop) begin
                    state_d = ST_IDLE;
                    addr_d  = '0;
                end else if (i_pause) begin
                    state_d = ST_PAUSE;
                end else if (i_lrck_fall) begin
                    sample_d = step_word;
                    cnt_d    = advance ? 4'd0 : cnt_q + 4'd1;
                    if (advance) begin
                        prev_d = i_sram_data;
                        if (at_end) begin
                            state_d = ST_IDLE;
                            addr_d  = '0;
                        end else begin
                            addr_d = addr_sum[ADDR_W-1:0];
                        end
                    end
                end
            end
            ST_PAUSE: begin
                if (i_stop) begin
                    state_d = ST_IDLE;
                    addr_d  = '0;
                end else if (!i_pause) begin
                    state_d = ST_PLAY;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= ST_IDLE;
            addr_q   <= '0;
            prev_q   <= '0;
            sample_q <= '0;
            cnt_q    <= 4'd0;
        end else begin
            state_q  <= state_d;
            addr_q   <= addr_d;
            prev_q   <= prev_d;
            sample_q <= sample_d;
            cnt_q    <= cnt_d;
        end
    end

    assign o_sram_addr = addr_q;
    assign o_sample    = sample_q;
    assign o_state     = state_q;

endmodule

/* design/aud_player_top.sv */
module aud_player_top
    import aud_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  logic [1:0]          i_wb_adr,
    input  logic [31:0]         i_wb_dat,
    output logic [31:0]         o_wb_dat,
    output logic                o_wb_ack,
    output logic [ADDR_W-1:0]   o_sram_addr,
    input  logic [SAMPLE_W-1:0] i_sram_data,
    output logic                o_dac_bclk,
    output logic                o_dac_lrck,
    output logic                o_dac_sdata
);

    logic                start_p;
    logic                stop_p;
    logic                pause;
    logic                fast;
    logic                interp;
    logic [3:0]          speed;
    logic [ADDR_W-1:0]   end_addr;
    play_state_e         state;
    logic                lrck_fall;
    logic [SAMPLE_W-1:0] sample;

    aud_wb_regs u_wb_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .i_state    (state),
        .i_addr     (o_sram_addr), // status shows the live sram address
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_start    (start_p),
        .o_stop     (stop_p),
        .o_pause    (pause),
        .o_fast     (fast),
        .o_interp   (interp),
        .o_speed    (speed),
        .o_end_addr (end_addr)
    );

    aud_dsp u_dsp (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (start_p),
        .i_stop      (stop_p),
        .i_pause     (pause),
        .i_fast      (fast),
        .i_interp    (interp),
        .i_speed     (speed),
        .i_end_addr  (end_addr),
        .i_lrck_fall (lrck_fall),
        .i_sram_data (i_sram_data),
        .o_sram_addr (o_sram_addr),
        .o_sample    (sample),
        .o_state     (state)
    );

    aud_i2s_tx u_i2s_tx (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_sample    (sample),
        .o_dac_bclk  (o_dac_bclk),
        .o_dac_lrck  (o_dac_lrck),
        .o_dac_sdata (o_dac_sdata),
        .o_lrck_fall (lrck_fall)
    );

endmodule

/* verification/aud_player_properties.sv */
module aud_player_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_bclk,
    input logic i_lrck,
    input logic i_sdata
);

    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_ack |=> !i_wb_ack)
        else $error("wishbone ack held longer than one cycle");

    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else $error("wishbone ack outside an active cycle");

    // right slot 0 still carries the left lsb
    a_right_silent: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_lrck && $past(i_lrck, 4)) |-> !i_sdata)
        else $error("serial data not zero in the right half");

    a_lrck_on_fall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $changed(i_lrck) |-> $fell(i_bclk))
        else $error("lr clock moved away from a bit clock falling edge");

endmodule

bind aud_player_top aud_player_properties u_props (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_ack (o_wb_ack),
    .i_bclk   (o_dac_bclk),
    .i_lrck   (o_dac_lrck),
    .i_sdata  (o_dac_sdata)
);

/* verification/aud_player_tb.sv */
module aud_player_tb
    import aud_pkg::*;
();

    localparam int N_ROWS = 6;
    localparam int MAX_FR = 16;

    // name, fast, interp, speed, end address, frames, pause frame (0 is none)
    string row_name   [N_ROWS] = '{"fast_s3", "slow_s2_hold", "slow_s0_as_1",
                                   "slow_s4_interp", "pause_resume", "end_stop"};
    int    row_fast   [N_ROWS] = '{1, 0, 0, 0, 1, 1};
    int    row_interp [N_ROWS] = '{0, 0, 0, 1, 0, 0};
    int    row_speed  [N_ROWS] = '{3, 2, 0, 4, 1, 2};
    int    row_end    [N_ROWS] = '{'hFFFFF, 'hFFFFF, 'hFFFFF, 'hFFFFF, 'hFFFFF, 9};
    int    row_frames [N_ROWS] = '{8, 6, 4, 12, 10, 8};
    int    row_pause  [N_ROWS] = '{0, 0, 0, 0, 3, 0};

    logic                i_clk;
    logic                i_rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [1:0]          wb_adr;
    logic [31:0]         wb_dat;
    logic [31:0]         wb_rdat;
    logic                wb_ack;
    logic [ADDR_W-1:0]   sram_addr;
    logic [SAMPLE_W-1:0] sram_data;
    logic                dac_bclk;
    logic                dac_lrck;
    logic                dac_sdata;

    logic [15:0] noise [64];
    logic [15:0] rx_q [$];
    int          exp_w [MAX_FR];
    int          exp_state;
    int          exp_paused_addr;
    int          seed = 32'h5c1d;
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt = 0;
    int          limit;

    aud_player_top u_aud_player_top (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_adr    (wb_adr),
        .i_wb_dat    (wb_dat),
        .o_wb_dat    (wb_rdat),
        .o_wb_ack    (wb_ack),
        .o_sram_addr (sram_addr),
        .i_sram_data (sram_data),
        .o_dac_bclk  (dac_bclk),
        .o_dac_lrck  (dac_lrck),
        .o_dac_sdata (dac_sdata)
    );

    function automatic int mem_word(input int addr);
        int w;
        w = (addr * 7919 + 3) & 'hFFFF;
        if (addr < 64) begin
            w = w ^ int'(noise[addr[5:0]]); // extra noise on the low words
        end
        return w;
    endfunction

    always_comb begin
        sram_data = 16'(mem_word(int'(sram_addr)));
    end

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // slot 0 of the i2s receiver is the delay bit and slot 16 holds the lsb
    initial begin : i2s_rx
        int          slot;
        logic        lr_prev;
        logic [15:0] word;
        slot    = 99;
        lr_prev = 1'b0;
        word    = '0;
        forever begin
            @(posedge dac_bclk);
            if (!dac_lrck && lr_prev) begin
                slot = 0;
            end else if (slot < 99) begin
                slot++;
            end
            lr_prev = dac_lrck;
            if (slot >= 1 && slot <= 16) begin
                word = {word[14:0], dac_sdata};
            end
            if (slot == 16) begin
                rx_q.push_back(word);
            end
        end
    end

    task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
        int waited;
        @(posedge i_clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= adr;
        wb_dat <= dat;
        waited = 0;
        do begin
            @(negedge i_clk); // ack and read data are stable mid cycle
            waited++;
        end while (!wb_ack && waited < 16);
        rdat = wb_rdat;
        assert (wb_ack) else begin
            $display("no wishbone ack from the DUT for address %0d", adr);
            test_errs++;
        end
        @(posedge i_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] rdat);
        wb_cycle(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("** Error %s: expected %0h, actual %0h", what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %-16s ok", name);
        end else begin
            fail_cnt++;
            $display("test %-16s failed with %0d errors", name, test_errs);
        end
    endtask

    function automatic int scale_word(input int v, input int s);
        longint p;
        if (s == 1) begin
            return v;
        end
        p = longint'(v) * longint'(RECIP[s[3:0]]);
        return int'(p >> 16);
    endfunction

    // per frame model of the playback rules with one update per lr clock fall
    function automatic void build_expected(input int r);
        int s;
        int addr;
        int prev;
        int cnt;
        int smp;
        int st;
        int nxt;
        bit adv;
        bit paused;
        s    = (row_speed[r] == 0) ? 1 : row_speed[r];
        addr = (row_fast[r] != 0) ? s : 1;
        prev = mem_word(0);
        cnt  = 0;
        smp  = 0;
        st   = 1;
        exp_paused_addr = 0;
        for (int j = 1; j <= row_frames[r]; j++) begin
            paused = row_pause[r] > 0 && j > row_pause[r] && j <= row_pause[r] + 3;
            if (st == 1 && !paused) begin
                if (row_interp[r] != 0 && row_fast[r] == 0) begin
                    smp = (scale_word(prev, s) * (s - cnt)
                           + scale_word(mem_word(addr), s) * cnt) & 'hFFFF;
                end else begin
                    smp = prev;
                end
                adv = row_fast[r] != 0 || cnt == s - 1;
                cnt = adv ? 0 : cnt + 1;
                if (adv) begin
                    nxt  = addr + ((row_fast[r] != 0) ? s : 1);
                    prev = mem_word(addr);
                    if (nxt >= row_end[r]) begin
                        st   = 0;
                        addr = 0;
                    end else begin
                        addr = nxt;
                    end
                end
            end
            if (j == row_pause[r]) begin
                exp_paused_addr = addr;
            end
            exp_w[j-1] = smp;
        end
        exp_state = st;
    endfunction

    task automatic check_reset();
        logic [31:0] rdat;
        test_errs = 0;
        wb_read(REG_STATUS, rdat);
        check_value("reset_idle status", 0, int'(rdat));
        wb_read(REG_CTRL, rdat);
        check_value("reset_idle ctrl", 0, int'(rdat));
        rx_q.delete();
        while (rx_q.size() < 3) begin
            @(posedge i_clk);
        end
        for (int k = 0; k < 3; k++) begin
            check_value($sformatf("reset_idle word %0d", k), 0, int'(rx_q[k]));
        end
        report_test("reset_idle");
    endtask

    task automatic run_row(input int r);
        logic [31:0] ctrl;
        logic [31:0] rdat;
        string       name;
        name      = row_name[r];
        test_errs = 0;
        for (int i = 0; i < 64; i++) begin
            noise[i] = (row_interp[r] != 0) ? 16'($random(seed)) : 16'h0;
        end
        ctrl = {20'd0, 4'(row_speed[r]), 3'd0, 1'(row_interp[r]), 1'(row_fast[r]), 3'b000};
        build_expected(r);
        wb_write(REG_END, 32'(row_end[r]));
        @(negedge dac_lrck); // start early in a frame so alignment is known
        wb_write(REG_CTRL, ctrl | 32'h1);
        rx_q.delete();
        for (int j = 1; j <= row_frames[r]; j++) begin
            @(negedge dac_lrck);
            if (j == 2) begin
                wb_read(REG_STATUS, rdat);
                check_value({name, " state in play"}, int'(ST_PLAY), int'(rdat[1:0]));
            end
            if (j == row_pause[r]) begin
                wb_write(REG_CTRL, ctrl | 32'h2);
                wb_read(REG_STATUS, rdat);
                check_value({name, " state in pause"}, int'(ST_PAUSE), int'(rdat[1:0]));
                check_value({name, " address at pause"}, exp_paused_addr,
                            int'(rdat[31:12]));
            end
            if (row_pause[r] > 0 && j == row_pause[r] + 3) begin
                wb_read(REG_STATUS, rdat);
                check_value({name, " still paused"}, int'(ST_PAUSE), int'(rdat[1:0]));
                check_value({name, " paused address"}, exp_paused_addr, int'(rdat[31:12]));
                wb_write(REG_CTRL, ctrl);
            end
        end
        while (rx_q.size() < row_frames[r] + 2) begin
            @(posedge i_clk);
        end
        // two words from before the start are still in flight
        for (int j = 0; j < row_frames[r]; j++) begin
            check_value($sformatf("%s word %0d", name, j), exp_w[j], int'(rx_q[j+2]));
        end
        wb_read(REG_STATUS, rdat);
        check_value({name, " final state"}, exp_state, int'(rdat[1:0]));
        if (exp_state == 0) begin
            check_value({name, " final address"}, 0, int'(rdat[31:12]));
        end
        wb_write(REG_CTRL, 32'h4);
        wb_read(REG_STATUS, rdat);
        check_value({name, " status after stop"}, 0, int'(rdat));
        report_test(name);
    endtask

    initial begin
        i_rst_n = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_adr  = 2'd0;
        wb_dat  = 32'd0;
        for (int i = 0; i < 64; i++) begin
            noise[i] = 16'h0;
        end
        limit = 2000;
        for (int r = 0; r < N_ROWS; r++) begin
            limit += (row_frames[r] + 4) * 128;
        end
        pass_cnt = 0;
        fail_cnt = 0;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        check_reset();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/aud_pkg.sv
design/aud_wb_regs.sv
design/aud_i2s_tx.sv
design/aud_dsp.sv
design/aud_player_top.sv
verification/aud_player_properties.sv
verification/aud_player_tb.sv

/* Makefile */
.PHONY: all lint clean

all: obj_dir/Vaud_player_tb
	./obj_dir/Vaud_player_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" sim.log || (echo "simulation did not complete"; exit 1)

obj_dir/Vaud_player_tb: filelist.f $(wildcard design/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module aud_player_tb \
		-f filelist.f -Mdir obj_dir

lint:
	verilator --lint-only --timing --assert --top-module aud_player_tb -f filelist.f

clean:
	rm -rf obj_dir sim.log
